/* design/fetch_pkg.sv */
package fetch_pkg;

    // Byte address of an instruction
    // Used for the PC, fetch address, redirect target and bus address
    typedef logic [31:0] pc_t;

    // Raw 32-bit instruction word as read from memory
    typedef logic [31:0] instr_t;

    // Control FSM states
    typedef enum logic [1:0] {
        // Single cycle after reset before any read is issued
        CTRL_INIT = 2'd0,
        // No read outstanding, free to issue
        CTRL_IDLE = 2'd1,
        // One read outstanding, its word goes to the buffer
        CTRL_BUSY = 2'd2,
        // One read outstanding, its word is stale and gets dropped
        CTRL_DROP = 2'd3
    } ctrl_state_t;

    // First fetch address after reset
    localparam pc_t RESET_PC = 32'h0000_1000;

    // Step between sequential instructions
    // No compressed instructions, so always one word
    localparam pc_t PC_STEP = 32'd4;

endpackage : fetch_pkg

/* design/fetch_pc_stage.sv */
`timescale 1ns/1ps

module fetch_pc_stage (
    input  logic           clk,
    input  logic           rst_n,

    // Redirect from later in the pipe, always accepted
    input  logic           redirect_en,
    input  fetch_pkg::pc_t redirect_pc,

    // Step to the next sequential word
    input  logic           pc_advance,

    // Address of the next word to fetch
    output fetch_pkg::pc_t fetch_pc
);

    import fetch_pkg::*;

    pc_t pc_q;
    pc_t pc_next;

    // Next PC selection
    // Redirect has priority over the sequential step
    always_comb begin
        pc_next = pc_q;
        if (redirect_en) begin
            // Fetch is word aligned, drop the byte offset
            pc_next = {redirect_pc[31:2], 2'b00};
        end else if (pc_advance) begin
            pc_next = pc_q + PC_STEP;
        end
    end

    // Program counter register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q <= RESET_PC;
        end else begin
            pc_q <= pc_next;
        end
    end

    // PC is the fetch address directly
    // The bus port captures it on rd_start
    assign fetch_pc = pc_q;

    // PC must be known once out of reset
    // It feeds the bus address and the decode PC downstream
    a_pc_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        !$isunknown(fetch_pc)
    ) else $error("fetch_pc unknown out of reset");

    // Redirect target should already be word aligned
    // Low bits are dropped above, so a misaligned target points to an upstream bug
    a_redirect_aligned: assert property (
        @(posedge clk) disable iff (!rst_n)
        redirect_en |-> (redirect_pc[1:0] == 2'b00)
    ) else $error("misaligned redirect target %h", redirect_pc);

endmodule : fetch_pc_stage

/* design/fetch_imem_port.sv */
`timescale 1ns/1ps

module fetch_imem_port (
    input  logic              clk,
    input  logic              rst_n,

    // Request side from control
    input  logic              rd_start,
    input  fetch_pkg::pc_t    rd_addr,
    output logic              rd_done,
    output fetch_pkg::instr_t rd_data,

    // Wishbone classic master, read only
    output logic              wb_cyc,
    output logic              wb_stb,
    output fetch_pkg::pc_t    wb_adr,
    input  fetch_pkg::instr_t wb_rdata,
    input  logic              wb_ack
);

    // High from the edge after rd_start through the ack cycle
    logic busy_q;

    // Bus cycle tracking
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
        end else if (rd_start) begin
            busy_q <= 1'b1;
        end else if (busy_q && wb_ack) begin
            // Release cyc and stb on the edge after ack
            busy_q <= 1'b0;
        end
    end

    // Address register
    // Loaded once per read and held for the whole strobe
    always_ff @(posedge clk) begin
        if (rd_start) begin
            wb_adr <= rd_addr;
        end
    end

    // Single transfer per cycle, so cyc and stb move together
    assign wb_cyc = busy_q;
    assign wb_stb = busy_q;

    // Ignore any ack outside our own cycle
    assign rd_done = busy_q && wb_ack;

    // Data only meaningful with rd_done
    assign rd_data = wb_rdata;

    // Address holds until the slave acks
    a_adr_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr)
    ) else $error("wb_adr changed during strobe");

    // Control must keep at most one read outstanding
    a_no_overlap: assert property (
        @(posedge clk) disable iff (!rst_n)
        rd_start |-> !busy_q
    ) else $error("rd_start while a read is still outstanding");

endmodule : fetch_imem_port

/* design/fetch_align_stage.sv */
`timescale 1ns/1ps

module fetch_align_stage (
    input  logic              clk,
    input  logic              rst_n,

    // Buffer control from the FSM
    input  logic              buf_load,
    input  logic              buf_flush,

    // Word returning from the bus and the current fetch PC
    input  fetch_pkg::pc_t    load_pc,
    input  fetch_pkg::instr_t load_instr,

    // Status back to control
    output logic              buf_full,
    output logic              buf_pop,

    // Decode handshake
    output logic              instr_valid,
    input  logic              instr_ready,
    output fetch_pkg::pc_t    instr_pc,
    output fetch_pkg::instr_t instr
);

    import fetch_pkg::*;

    logic   full_q;
    pc_t    pc_q;
    instr_t instr_q;

    // PC stepped on the rd_start edge, so the returning word sits one step behind
    // Any redirect in between sends control to DROP, so no load sees a moved PC
    pc_t word_pc;
    assign word_pc = load_pc - PC_STEP;

    // Occupancy with flush winning over a same-cycle load
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            full_q <= 1'b0;
        end else if (buf_flush) begin
            full_q <= 1'b0;
        end else if (buf_load) begin
            full_q <= 1'b1;
        end else if (buf_pop) begin
            full_q <= 1'b0;
        end
    end

    // Payload captured with each load
    always_ff @(posedge clk) begin
        if (buf_load) begin
            pc_q    <= word_pc;
            instr_q <= load_instr;
        end
    end

    assign buf_full = full_q;

    // Valid dropped in the redirect cycle itself
    assign instr_valid = full_q && !buf_flush;
    assign buf_pop     = instr_valid && instr_ready;

    assign instr_pc = pc_q;
    assign instr    = instr_q;

    // Stalled item holds until taken, unless a redirect throws it away
    a_hold_stall: assert property (
        @(posedge clk) disable iff (!rst_n)
        instr_valid && !instr_ready |=>
            buf_flush || (instr_valid && $stable(instr_pc) && $stable(instr))
    ) else $error("decode output changed while stalled");

endmodule : fetch_align_stage

/* design/fetch_ctrl.sv */
`timescale 1ns/1ps

module fetch_ctrl (
    input  logic clk,
    input  logic rst_n,

    input  logic redirect_en,

    // Buffer status from the align stage
    input  logic buf_full,
    input  logic buf_pop,

    // End of the outstanding read
    input  logic rd_done,

    output logic pc_advance,
    output logic rd_start,
    output logic buf_load,
    output logic buf_flush
);

    import fetch_pkg::*;

    ctrl_state_t state_q;
    ctrl_state_t state_next;

    // Buffer can take a word if empty or emptied this cycle
    logic buf_space;
    logic issue;

    assign buf_space = !buf_full || buf_pop;

    // Never issue during a redirect, the PC is being reloaded
    assign issue = (state_q == CTRL_IDLE) && !redirect_en && buf_space;

    assign rd_start   = issue;
    // PC steps on the same edge the port captures it
    assign pc_advance = issue;

    // Only a live read fills the buffer; a redirect in the ack cycle kills it
    assign buf_load  = (state_q == CTRL_BUSY) && rd_done && !redirect_en;
    assign buf_flush = redirect_en;

    // Next state
    always_comb begin
        state_next = state_q;
        case (state_q)
            CTRL_INIT: state_next = CTRL_IDLE;
            CTRL_IDLE: begin
                if (issue) begin
                    state_next = CTRL_BUSY;
                end
            end
            CTRL_BUSY: begin
                if (rd_done) begin
                    state_next = CTRL_IDLE;
                end else if (redirect_en) begin
                    // Word still in flight belongs to the old stream
                    state_next = CTRL_DROP;
                end
            end
            CTRL_DROP: begin
                if (rd_done) begin
                    state_next = CTRL_IDLE;
                end
            end
            default: state_next = CTRL_INIT;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= CTRL_INIT;
        end else begin
            state_q <= state_next;
        end
    end

    a_state_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        !$isunknown(state_q)
    ) else $error("control state unknown");

    // Back-pressure at issue time must leave room when the word returns
    a_no_overflow: assert property (
        @(posedge clk) disable iff (!rst_n)
        buf_load |-> (!buf_full || buf_pop)
    ) else $error("buffer overflow in state %s", state_q.name());

endmodule : fetch_ctrl

/* design/fetch_top.sv */
`timescale 1ns/1ps

module fetch_top (
    input  logic              clk,
    input  logic              rst_n,

    // Redirect request, one cycle, no handshake
    input  logic              redirect_en,
    input  fetch_pkg::pc_t    redirect_pc,

    // Wishbone classic instruction bus
    output logic              wb_cyc,
    output logic              wb_stb,
    output fetch_pkg::pc_t    wb_adr,
    input  fetch_pkg::instr_t wb_rdata,
    input  logic              wb_ack,

    // Decode side
    output logic              instr_valid,
    input  logic              instr_ready,
    output fetch_pkg::pc_t    instr_pc,
    output fetch_pkg::instr_t instr
);

    import fetch_pkg::*;

    // Control to datapath
    logic   pc_advance;
    logic   rd_start;
    logic   buf_load;
    logic   buf_flush;

    // Datapath back to control
    logic   rd_done;
    logic   buf_full;
    logic   buf_pop;

    pc_t    fetch_pc;
    instr_t rd_data;

    fetch_ctrl u_fetch_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .redirect_en (redirect_en),
        .buf_full    (buf_full),
        .buf_pop     (buf_pop),
        .rd_done     (rd_done),
        .pc_advance  (pc_advance),
        .rd_start    (rd_start),
        .buf_load    (buf_load),
        .buf_flush   (buf_flush)
    );

    fetch_pc_stage u_fetch_pc_stage (
        .clk         (clk),
        .rst_n       (rst_n),
        .redirect_en (redirect_en),
        .redirect_pc (redirect_pc),
        .pc_advance  (pc_advance),
        .fetch_pc    (fetch_pc)
    );

    fetch_imem_port u_fetch_imem_port (
        .clk      (clk),
        .rst_n    (rst_n),
        .rd_start (rd_start),
        .rd_addr  (fetch_pc),
        .rd_done  (rd_done),
        .rd_data  (rd_data),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_adr   (wb_adr),
        .wb_rdata (wb_rdata),
        .wb_ack   (wb_ack)
    );

    // Align stage sees the live PC, the word PC is derived inside
    fetch_align_stage u_fetch_align_stage (
        .clk         (clk),
        .rst_n       (rst_n),
        .buf_load    (buf_load),
        .buf_flush   (buf_flush),
        .load_pc     (fetch_pc),
        .load_instr  (rd_data),
        .buf_full    (buf_full),
        .buf_pop     (buf_pop),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .instr_pc    (instr_pc),
        .instr       (instr)
    );

endmodule : fetch_top

/* testbench/tb_imem_model.sv */
`timescale 1ns/1ps

module tb_imem_model (
    input  logic              clk,
    input  logic              rst_n,

    // Upper bound on wait states for the current test
    input  int                max_wait,

    // Wishbone classic slave side for reads only
    input  logic              wb_cyc,
    input  logic              wb_stb,
    input  fetch_pkg::pc_t    wb_adr,
    output fetch_pkg::instr_t wb_rdata,
    output logic              wb_ack
);

    import fetch_pkg::*;

    integer seed;

    // Cycles already spent on the current strobe
    int wait_cnt;
    // Wait states chosen for the current strobe
    int wait_len;

    initial begin
        seed = 32'hd9e8;
    end

    // Ack once the chosen number of wait states has passed
    assign wb_ack = wb_cyc && wb_stb && (wait_cnt == wait_len);

    // Word depends on every address bit
    assign wb_rdata = wb_adr ^ 32'hA5A5_0000;

    always @(posedge clk) begin
        if (!rst_n) begin
            wait_cnt <= 0;
            wait_len <= 0;
        end else if (wb_ack) begin
            // Pick the delay of the next strobe now
            wait_cnt <= 0;
            wait_len <= $unsigned($random(seed)) % (max_wait + 1);
        end else if (wb_cyc && wb_stb) begin
            wait_cnt <= wait_cnt + 1;
        end
    end

endmodule : tb_imem_model

/* testbench/tb_fetch_top.sv */
`timescale 1ns/1ps

module tb_fetch_top;

    import fetch_pkg::*;

    logic   clk;
    logic   rst_n;
    logic   redirect_en;
    pc_t    redirect_pc;
    logic   wb_cyc;
    logic   wb_stb;
    pc_t    wb_adr;
    instr_t wb_rdata;
    logic   wb_ack;
    logic   instr_valid;
    logic   instr_ready;
    pc_t    instr_pc;
    instr_t instr;

    int     mem_max_wait;

    // Test table with one entry per data file line
    pc_t    tgt_q[$];
    int     cnt_q[$];
    int     wait_q[$];
    int     pct_q[$];

    integer seed;
    int     error_count;
    int     check_count;
    longint limit_cycles;

    // Scoreboard PC of the next item decode should receive
    pc_t    exp_pc;

    // Strobe monitor state
    logic   stb_prev;
    pc_t    stb_adr;

    fetch_top u_fetch_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .redirect_en (redirect_en),
        .redirect_pc (redirect_pc),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_adr      (wb_adr),
        .wb_rdata    (wb_rdata),
        .wb_ack      (wb_ack),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .instr_pc    (instr_pc),
        .instr       (instr)
    );

    tb_imem_model u_imem_model (
        .clk      (clk),
        .rst_n    (rst_n),
        .max_wait (mem_max_wait),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_adr   (wb_adr),
        .wb_rdata (wb_rdata),
        .wb_ack   (wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        check_count++;
        if (actual !== expected) begin
            $display("ERROR at %0t: %s is %h, expected %h", $time, what, actual, expected);
            error_count++;
        end
    endtask

    // Reads the test table and sizes the watchdog from it
    task automatic load_tests();
        int    fd;
        string line;
        pc_t   t;
        int    c;
        int    w;
        int    p;
        fd = $fopen("testbench/fetch_tests.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                // Skip comments and blank lines
                if (line.len() > 0 && line[0] != "#" &&
                    $sscanf(line, "%h %d %d %d", t, c, w, p) == 4) begin
                    tgt_q.push_back(t);
                    cnt_q.push_back(c);
                    wait_q.push_back(w);
                    pct_q.push_back(p);
                    // Low ready rates stretch each item, so scale by them
                    limit_cycles += c * (w + 4) * 100 / ((p > 0) ? p : 1) + 20;
                end
            end
            $fclose(fd);
            // Reset and start-up margin
            if (limit_cycles > 0) begin
                limit_cycles += 200;
            end
        end
    endtask

    // Reset held over 8 rising edges
    task automatic apply_reset();
        repeat (7) @(posedge clk);
        @(negedge clk);
        check_equal(wb_cyc, 1'b0, "wb_cyc in reset");
        check_equal(wb_stb, 1'b0, "wb_stb in reset");
        check_equal(instr_valid, 1'b0, "instr_valid in reset");
        @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        // Control sits in its init state here with the bus still quiet
        check_equal(wb_cyc, 1'b0, "wb_cyc right after reset");
        check_equal(wb_stb, 1'b0, "wb_stb right after reset");
        check_equal(instr_valid, 1'b0, "instr_valid right after reset");
        @(posedge clk);
    endtask

    // Try to land the redirect while a read waits for ack
    task automatic pulse_redirect(input pc_t target);
        int tries;
        tries = 0;
        @(negedge clk);
        while (!(wb_stb && !wb_ack) && tries < 8) begin
            @(negedge clk);
            tries++;
        end
        @(posedge clk);
        redirect_en <= 1'b1;
        redirect_pc <= target;
        @(posedge clk);
        redirect_en <= 1'b0;
    endtask

    task automatic run_test(input int idx, input pc_t target, input int count,
                            input int max_wait, input int pct);
        int     n;
        int     errors_before;
        logic   held;
        pc_t    held_pc;
        instr_t held_instr;
        pc_t    start_pc;
        errors_before = error_count;
        n = 0;
        held = 1'b0;
        mem_max_wait <= max_wait;
        // Target of zero keeps the running stream
        if (target != '0) begin
            pulse_redirect(target);
            exp_pc = {target[31:2], 2'b00};
        end
        start_pc = exp_pc;
        while (n < count) begin
            @(posedge clk);
            instr_ready <= ($unsigned($random(seed)) % 100) < pct;
            @(negedge clk);
            // Stalled item must still be offered unchanged
            if (held) begin
                check_equal(instr_valid, 1'b1, "instr_valid during stall");
                check_equal(instr_pc, held_pc, "instr_pc during stall");
                check_equal(instr, held_instr, "instr during stall");
            end
            held       = instr_valid && !instr_ready;
            held_pc    = instr_pc;
            held_instr = instr;
            // Transfer happens on the coming rising edge
            if (instr_valid && instr_ready) begin
                check_equal(instr_pc, exp_pc, "instr_pc");
                check_equal(instr, exp_pc ^ 32'hA5A5_0000, "instr");
                exp_pc = exp_pc + 32'd4;
                n++;
            end
        end
        // Last transfer still sees ready high on this edge
        @(posedge clk);
        instr_ready <= 1'b0;
        $display("Test %0d: start %h, %0d instructions, up to %0d wait states, ready %0d%%: %s",
                 idx + 1, start_pc, count, max_wait, pct,
                 (error_count == errors_before) ? "passed" : "failed");
    endtask

    // Strobe moves with cyc and stays up with a fixed address until the ack
    always @(negedge clk) begin
        if (rst_n) begin
            check_equal(wb_stb, wb_cyc, "wb_stb against wb_cyc");
        end
        if (rst_n && stb_prev) begin
            check_equal(wb_stb, 1'b1, "wb_stb before ack");
            check_equal(wb_adr, stb_adr, "wb_adr during strobe");
        end
        stb_prev <= rst_n && wb_stb && !wb_ack;
        stb_adr  <= wb_adr;
    end

    initial begin
        int i;
        rst_n        = 1'b0;
        redirect_en  = 1'b0;
        redirect_pc  = '0;
        instr_ready  = 1'b0;
        mem_max_wait = 0;
        stb_prev     = 1'b0;
        seed         = 32'hd9e8;
        error_count  = 0;
        check_count  = 0;
        limit_cycles = 0;
        exp_pc       = RESET_PC;

        load_tests();
        if (tgt_q.size() == 0) begin
            $display("No test could be read from testbench/fetch_tests.txt");
            error_count++;
        end else begin
            apply_reset();
            for (i = 0; i < tgt_q.size(); i++) begin
                run_test(i, tgt_q[i], cnt_q[i], wait_q[i], pct_q[i]);
            end
        end
        $display("%0d tests, %0d checks, %0d errors", tgt_q.size(), check_count, error_count);
        if (error_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Watchdog with its budget taken from the test table
    initial begin
        wait (limit_cycles > 0);
        #(limit_cycles * 100);
        $display("Timeout after %0d cycles, decode stopped receiving instructions",
                 limit_cycles);
        $display("TEST FAILED");
        $finish;
    end

endmodule : tb_fetch_top

/* testbench/fetch_tests.txt */
# target_hex (0 = no redirect) instr_count max_wait_states ready_percent
# Items expected from target upward in steps of 4, word = pc xor a5a50000
00000000 16 0 100
00000000 12 3 100
00002000 20 0 50
00002000 10 5 70
00000000 16 2 30
80000000 24 7 90
00000100 8 1 100
00000104 8 4 40
fffffff0 12 2 80
00000000 10 0 20
00003ffc 20 6 60
00001000 16 3 100
00000000 16 7 50
0000abc0 30 1 75
00000008 12 0 100
00004000 25 5 35

/* verilog.f */
design/fetch_pkg.sv
design/fetch_pc_stage.sv
design/fetch_imem_port.sv
design/fetch_align_stage.sv
design/fetch_ctrl.sv
design/fetch_top.sv
testbench/tb_imem_model.sv
testbench/tb_fetch_top.sv

/* Bender.yml */
package:
  name: fetch_front_end

sources:
  - design/fetch_pkg.sv
  - design/fetch_pc_stage.sv
  - design/fetch_imem_port.sv
  - design/fetch_align_stage.sv
  - design/fetch_ctrl.sv
  - design/fetch_top.sv
  - target: test
    files:
      - testbench/tb_imem_model.sv
      - testbench/tb_fetch_top.sv
